// File: logic/pixel_pkg.sv
package pixel_pkg;

	// One 8-bit colour sample, unsigned
	typedef logic [7:0] channel_t;

	// Channel layout inside a pixel word
	// Red sits in the top byte, blue in the bottom byte
	typedef struct packed {
		channel_t red;
		channel_t green;
		channel_t blue;
	} rgb_t;

	// Same 24 bits seen two ways
	// raw is what gets stored and carried on ports
	// rgb is used where the channels are split apart
	typedef union packed {
		logic [23:0] raw;
		rgb_t rgb;
	} pixel_t;

endpackage

// File: logic/kernel_pkg.sv
package kernel_pkg;

	// Signed coefficient, range -8..7
	typedef logic signed [3:0] coef_t;

	// Signed sum of the nine products
	// Sharpen sum stays within -1020..1275 for 8-bit input
	typedef logic signed [13:0] acc_t;

	// Sharpen kernel, row-major
	// Index 0 is the oldest column of the oldest row
	// Row 0 is the top of the window
	localparam coef_t KERNEL [0:8] = '{
		4'sd0,
		-4'sd1,
		4'sd0,
		-4'sd1,
		4'sd5,
		-4'sd1,
		4'sd0,
		-4'sd1,
		4'sd0
	};

	// Largest value a channel can carry after clamping
	localparam acc_t CLAMP_MAX = 14'sd255;

endpackage

// File: logic/filter_line_buffer.sv
`timescale 1ns/100ps

module filter_line_buffer
	import pixel_pkg::*;
#(
	parameter int IMG_WIDTH = 320
) (
	input logic clk,
	input logic reset,
	input logic i_valid,
	input pixel_t i_pixel,
	output pixel_t o_tap0,
	output pixel_t o_tap1,
	output pixel_t o_tap2
);

	// One padded row, zero border included
	localparam int DEPTH = IMG_WIDTH + 2;

	// row1_q holds the previous padded row, row2_q the one before it
	logic [23:0] row1_q [DEPTH];
	logic [23:0] row2_q [DEPTH];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				row1_q[i] <= '0;
				row2_q[i] <= '0;
			end
		end else if (i_valid) begin
			// Oldest word of row 1 falls into row 2
			row1_q[0] <= i_pixel.raw;
			row2_q[0] <= row1_q[DEPTH-1];
			for (int i = 1; i < DEPTH; i++) begin
				row1_q[i] <= row1_q[i-1];
				row2_q[i] <= row2_q[i-1];
			end
		end
	end

	// Three samples of the same padded column
	assign o_tap0 = i_pixel;
	assign o_tap1 = row1_q[DEPTH-1];
	assign o_tap2 = row2_q[DEPTH-1];

endmodule

// File: logic/filter_pos_counter.sv
`timescale 1ns/100ps

module filter_pos_counter #(
	parameter int IMG_WIDTH = 320,
	parameter int IMG_HEIGHT = 240
) (
	input logic clk,
	input logic reset,
	input logic i_valid,
	output logic [12:0] o_col,
	output logic [12:0] o_row,
	output logic o_frame_last
);

	// Padded frame geometry
	localparam int PAD_W = IMG_WIDTH + 2;
	localparam int PAD_H = IMG_HEIGHT + 2;
	localparam logic [12:0] COL_LAST = 13'(PAD_W - 1);
	localparam logic [12:0] ROW_LAST = 13'(PAD_H - 1);

	// Position of the pixel now on i_pixel
	logic [12:0] col_q;
	logic [12:0] row_q;
	logic col_wrap;

	assign col_wrap = (col_q == COL_LAST);

	always_ff @(posedge clk) begin
		if (reset) begin
			col_q <= '0;
			row_q <= '0;
		end else if (i_valid) begin
			if (col_wrap) begin
				col_q <= '0;
				// Row wraps back to 0 at the end of the padded frame
				if (row_q == ROW_LAST) begin
					row_q <= '0;
				end else begin
					row_q <= row_q + 13'd1;
				end
			end else begin
				col_q <= col_q + 13'd1;
			end
		end
	end

	assign o_col = col_q;
	assign o_row = row_q;

	// Bottom right corner of the padded frame
	assign o_frame_last = col_wrap && (row_q == ROW_LAST);

endmodule

// File: logic/filter_frame_ctrl.sv
`timescale 1ns/100ps

module filter_frame_ctrl (
	input logic clk,
	input logic reset,
	input logic i_valid,
	input logic [12:0] i_col,
	input logic [12:0] i_row,
	input logic i_frame_last,
	output logic o_win_valid,
	output logic o_win_done
);

	typedef enum logic [1:0] {
		IDLE,
		FILL,
		RUN,
		FRAME_END
	} state_t;

	state_t state_q;
	state_t state_d;
	logic win_valid_q;
	logic win_done_q;

	// Next state, only taken on an advance
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				state_d = FILL;
			end
			FILL: begin
				// First pixel of padded row 2 starts real windows
				if (i_row >= 13'd2) begin
					state_d = RUN;
				end
			end
			RUN: begin
				if (i_frame_last) begin
					state_d = FRAME_END;
				end
			end
			FRAME_END: begin
				// Next frame may start straight away
				state_d = FILL;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			win_valid_q <= 1'b0;
			win_done_q <= 1'b0;
		end else if (i_valid) begin
			state_q <= state_d;
			// Window is complete once two border columns and rows are in
			win_valid_q <= (state_q == RUN) && (i_row >= 13'd2) && (i_col >= 13'd2);
			// One advance after the last window of the frame
			win_done_q <= (state_q == FRAME_END);
		end
	end

	assign o_win_valid = win_valid_q;
	assign o_win_done = win_done_q;

endmodule

// File: logic/filter_conv_channel.sv
`timescale 1ns/100ps

module filter_conv_channel
	import pixel_pkg::*;
	import kernel_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic i_valid,
	input logic i_win_valid,
	input logic i_win_done,
	input channel_t i_top,
	input channel_t i_mid,
	input channel_t i_bot,
	output logic o_valid,
	output logic o_done,
	output channel_t o_value
);

	// 3x3 window, win_q[row][col]
	// Row 0 is the oldest padded row, col 2 the newest sample
	channel_t win_q [3][3];

	// Second stage
	acc_t mac_sum;
	acc_t sum_q;
	logic sum_valid_q;
	logic sum_done_q;

	// Third stage
	channel_t value_q;
	logic out_valid_q;
	logic out_done_q;

	// Window shift, columns move left by one per advance
	always_ff @(posedge clk) begin
		if (i_valid) begin
			for (int r = 0; r < 3; r++) begin
				win_q[r][0] <= win_q[r][1];
				win_q[r][1] <= win_q[r][2];
			end
			win_q[0][2] <= i_top;
			win_q[1][2] <= i_mid;
			win_q[2][2] <= i_bot;
		end
	end

	// Nine products against the fixed kernel
	// Samples are zero-extended so they stay positive once signed
	always_comb begin
		mac_sum = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				mac_sum = mac_sum + acc_t'($signed({1'b0, win_q[r][c]})) * acc_t'(KERNEL[r*3 + c]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			sum_q <= mac_sum;
			// Clamp to 0..255
			if (sum_q < 0) begin
				value_q <= '0;
			end else if (sum_q > CLAMP_MAX) begin
				value_q <= 8'd255;
			end else begin
				value_q <= sum_q[7:0];
			end
		end
	end

	// Strobes follow the data through both stages
	always_ff @(posedge clk) begin
		if (reset) begin
			sum_valid_q <= 1'b0;
			sum_done_q <= 1'b0;
			out_valid_q <= 1'b0;
			out_done_q <= 1'b0;
		end else if (i_valid) begin
			sum_valid_q <= i_win_valid;
			sum_done_q <= i_win_done;
			out_valid_q <= sum_valid_q;
			out_done_q <= sum_done_q;
		end
	end

	// No output strobe while the pipeline is stalled
	assign o_valid = out_valid_q && i_valid;
	assign o_done = out_done_q;
	assign o_value = value_q;

endmodule

// File: logic/image_filter_top.sv
`timescale 1ns/100ps

module image_filter_top
	import pixel_pkg::*;
#(
	parameter int IMG_WIDTH = 320,
	parameter int IMG_HEIGHT = 240
) (
	input logic clk,
	input logic reset,
	input logic i_valid,
	input pixel_t i_pixel,
	output logic o_valid,
	output logic o_done,
	output pixel_t o_pixel
);

	// Position within the padded frame
	logic [12:0] col;
	logic [12:0] row;
	logic frame_last;

	// Window strobes from the controller
	logic win_valid;
	logic win_done;

	// Vertical taps, tap2 is the oldest row
	pixel_t tap0;
	pixel_t tap1;
	pixel_t tap2;

	// Filtered channels
	channel_t red_value;
	channel_t green_value;
	channel_t blue_value;

	filter_pos_counter #(
		.IMG_WIDTH(IMG_WIDTH),
		.IMG_HEIGHT(IMG_HEIGHT)
	) u_filter_pos_counter (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.o_col(col),
		.o_row(row),
		.o_frame_last(frame_last)
	);

	filter_frame_ctrl u_filter_frame_ctrl (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_col(col),
		.i_row(row),
		.i_frame_last(frame_last),
		.o_win_valid(win_valid),
		.o_win_done(win_done)
	);

	filter_line_buffer #(
		.IMG_WIDTH(IMG_WIDTH)
	) u_filter_line_buffer (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_pixel(i_pixel),
		.o_tap0(tap0),
		.o_tap1(tap1),
		.o_tap2(tap2)
	);

	// Red carries the strobes for the whole pixel
	filter_conv_channel u_conv_r (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_win_valid(win_valid),
		.i_win_done(win_done),
		.i_top(tap2.rgb.red),
		.i_mid(tap1.rgb.red),
		.i_bot(tap0.rgb.red),
		.o_valid(o_valid),
		.o_done(o_done),
		.o_value(red_value)
	);

	filter_conv_channel u_conv_g (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_win_valid(win_valid),
		.i_win_done(win_done),
		.i_top(tap2.rgb.green),
		.i_mid(tap1.rgb.green),
		.i_bot(tap0.rgb.green),
		.o_valid(),
		.o_done(),
		.o_value(green_value)
	);

	filter_conv_channel u_conv_b (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_win_valid(win_valid),
		.i_win_done(win_done),
		.i_top(tap2.rgb.blue),
		.i_mid(tap1.rgb.blue),
		.i_bot(tap0.rgb.blue),
		.o_valid(),
		.o_done(),
		.o_value(blue_value)
	);

	// Put the channels back together
	assign o_pixel.rgb = '{red: red_value, green: green_value, blue: blue_value};

endmodule

// File: verif/image_filter_tb.sv
`timescale 1ns/100ps

module image_filter_tb
	import pixel_pkg::*;
();

	// Small frame so the whole picture fits in the stim file
	localparam int IMG_W = 4;
	localparam int IMG_H = 3;
	localparam int NUM_INPUTS = (IMG_W + 2) * (IMG_H + 2);
	localparam int NUM_OUTPUTS = IMG_W * IMG_H;
	localparam int MAX_GAP = 3;
	localparam int RESET_CYCLES = 4;
	// Advances needed after the last pixel to see the last output and o_done
	localparam int FLUSH_ADVANCES = 4;
	localparam logic [23:0] RANDOM_GAP = 24'hFF;
	// Word 0 is the frame count, then gap and pixel pairs, then expected pixels
	localparam int EXP_BASE = 1 + 2 * NUM_INPUTS;

	logic clk;
	logic reset;
	logic i_valid;
	pixel_t i_pixel;
	logic o_valid;
	logic o_done;
	pixel_t o_pixel;

	logic [23:0] stim_mem [0:EXP_BASE + NUM_OUTPUTS - 1];
	int frames;
	logic stim_loaded;
	logic checking;
	logic input_seen;
	// Set by the last output of a frame, o_done is due on the next advance
	logic done_due;
	logic [31:0] rand_state;
	pixel_t in_pix;
	pixel_t expected_pix;
	int out_count;
	int frame_outs;
	int done_count;
	int mismatch_count;
	int other_count;

	image_filter_top #(
		.IMG_WIDTH(IMG_W),
		.IMG_HEIGHT(IMG_H)
	) u_image_filter_top (
		.clk(clk),
		.reset(reset),
		.i_valid(i_valid),
		.i_pixel(i_pixel),
		.o_valid(o_valid),
		.o_done(o_done),
		.o_pixel(o_pixel)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_pixel(input pixel_t actual, input pixel_t expected, input int index);
		if (actual.raw !== expected.raw) begin
			mismatch_count++;
			$display("Mismatch at %0t: output %0d got r=%02h g=%02h b=%02h, want r=%02h g=%02h b=%02h",
				$time, index, actual.rgb.red, actual.rgb.green, actual.rgb.blue,
				expected.rgb.red, expected.rgb.green, expected.rgb.blue);
		end
	endtask

	task automatic compare_done(input logic actual, input logic expected);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Mismatch at %0t: o_done is %b, expected %b", $time, actual, expected);
		end
	endtask

	// Idle cycles first, then one advance with the pixel
	task automatic send_pixel(input pixel_t pix, input logic [23:0] gap_code);
		int gap;
		if (gap_code == RANDOM_GAP) begin
			rand_state = xorshift32(rand_state);
			gap = int'(rand_state % (MAX_GAP + 1));
		end else begin
			gap = int'(gap_code);
		end
		repeat (gap) begin
			@(negedge clk);
			i_valid = 1'b0;
			i_pixel = '0;
		end
		@(negedge clk);
		i_valid = 1'b1;
		i_pixel = pix;
	endtask

	// Zero pixels that push the last window out of the pipeline
	task automatic flush_pipeline();
		repeat (FLUSH_ADVANCES) begin
			@(negedge clk);
			i_valid = 1'b1;
			i_pixel = '0;
		end
		@(negedge clk);
		i_valid = 1'b0;
	endtask

	// Outputs settle between the falling-edge drive and the next rising edge
	always @(negedge clk) begin
		#1;
		if (checking) begin
			if (o_valid === 1'b1 && i_valid !== 1'b1) begin
				other_count++;
				$display("Error at %0t: o_valid is high while i_valid is low", $time);
			end
			if (i_valid === 1'b1) begin
				input_seen = 1'b1;
				compare_done(o_done, done_due);
				if (o_done === 1'b1) begin
					done_count++;
				end
				done_due = 1'b0;
				if (o_valid === 1'b1) begin
					if (out_count >= NUM_OUTPUTS * frames) begin
						other_count++;
						$display("Error at %0t: extra output pixel after %0d outputs", $time,
							NUM_OUTPUTS * frames);
					end else begin
						expected_pix.raw = stim_mem[EXP_BASE + frame_outs];
						compare_pixel(o_pixel, expected_pix, out_count);
						frame_outs++;
						if (frame_outs == NUM_OUTPUTS) begin
							frame_outs = 0;
							done_due = 1'b1;
						end
					end
					out_count++;
				end
			end else if (!input_seen) begin
				// Nothing may come out before the first input
				compare_done(o_done, 1'b0);
			end
		end
	end

	initial begin
		reset = 1'b1;
		i_valid = 1'b0;
		i_pixel = '0;
		checking = 1'b0;
		input_seen = 1'b0;
		done_due = 1'b0;
		rand_state = 32'd25;
		out_count = 0;
		frame_outs = 0;
		done_count = 0;
		mismatch_count = 0;
		other_count = 0;
		stim_loaded = 1'b0;
		$readmemh("verif/filter_stim.txt", stim_mem);
		frames = int'(stim_mem[0]);
		if ($isunknown(stim_mem[0]) || frames == 0) begin
			other_count++;
			frames = 0;
			$display("Error: stimulus file gave no frame count");
		end
		stim_loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		checking = 1'b1;
		// Quiet cycles right after reset
		repeat (3) @(negedge clk);
		// Frames follow each other with no extra idle time
		for (int f = 0; f < frames; f++) begin
			for (int i = 0; i < NUM_INPUTS; i++) begin
				in_pix.raw = stim_mem[2 + 2 * i];
				send_pixel(in_pix, stim_mem[1 + 2 * i]);
			end
		end
		flush_pipeline();
		repeat (4) @(negedge clk);
		checking = 1'b0;
		if (out_count < NUM_OUTPUTS * frames) begin
			other_count++;
			$display("Error: only %0d of %0d output pixels arrived", out_count,
				NUM_OUTPUTS * frames);
		end
		if (done_count != frames) begin
			other_count++;
			$display("Error: o_done pulsed %0d times for %0d frames", done_count, frames);
		end
		$display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_count);
		if (mismatch_count == 0 && other_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Worst case is every input behind the longest gap
	initial begin
		int limit;
		wait (stim_loaded === 1'b1);
		limit = (NUM_INPUTS * (MAX_GAP + 1) + 20) * ((frames > 0) ? frames : 1) + RESET_CYCLES;
		repeat (limit) @(posedge clk);
		$display("Error: run did not finish within %0d cycles", limit);
		$display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_count);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: files.f
logic/pixel_pkg.sv
logic/kernel_pkg.sv
logic/filter_line_buffer.sv
logic/filter_pos_counter.sv
logic/filter_frame_ctrl.sv
logic/filter_conv_channel.sv
logic/image_filter_top.sv
verif/image_filter_tb.sv

// File: verif/filter_stim.txt
// Word 0 is the frame count, then 30 lines of gap and padded pixel RRGGBB
// Gap FF means a random gap, then 12 expected output pixels RRGGBB in raster order
02
// Padded row 0, top border
00 000000
01 000000
00 000000
FF 000000
00 000000
02 000000
// Padded row 1
00 000000
00 C82800
FF 0A2801
03 322802
00 642803
01 000000
// Padded row 2
FF 000000
00 1E2804
02 FF3C05
00 283C06
FF 3C2807
00 000000
// Padded row 3
01 000000
FF 5A2808
00 142809
00 46280A
03 80280B
FF 000000
// Padded row 4, bottom border
00 000000
02 000000
FF 000000
00 000000
01 000000
00 000000
// Expected row 0
FF7800
003C00
643C00
FF7806
// Expected row 1
003C07
FF7805
007806
203C0F
// Expected row 2
FF781B
003C16
A23C18
FF7826
